// File: fir_accel.f
source/fir_bus_pkg.sv
source/fir_dsp_pkg.sv
source/sram_rw_if.sv
source/fir_sram.sv
source/axil_cfg.sv
source/fir_engine.sv
source/fir_accel.sv
tb/fir_accel_checker.sv
tb/fir_accel_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the fir_accel testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module fir_accel_tb -f fir_accel.f -o fir_accel_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/fir_accel_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: source/axil_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module axil_cfg
  import fir_bus_pkg::*;
  import fir_dsp_pkg::*;
#(
  parameter int TAP_MAX = TAP_MAX_DEF
) (
  input  wire logic  axis_clk,
  input  wire logic  axis_rst_n,
  input  wire logic  awvalid,
  input  wire addr_t awaddr,
  output logic       awready,
  input  wire logic  wvalid,
  input  wire word_t wdata,
  output logic       wready,
  input  wire logic  arvalid,
  input  wire addr_t araddr,
  output logic       arready,
  output logic       rvalid,
  output word_t      rdata,
  input  wire logic  rready,
  sram_rw_if.host    tap_rw,
  output logic       start,
  output tap_idx_t   tap_count,
  input  wire logic  run_done
);

  ap_state_e ap_state;
  word_t     data_len_q;
  word_t     tap_num_q;
  word_t     rd_word_q;
  word_t     rd_sel;
  word_t     ap_word;
  tap_idx_t  last_tap;
  logic      rd_tap_q;
  logic      wr_pend;
  logic      wr_en;
  logic      rd_en;
  logic      busy;

  // word offset into the coefficient window
  function automatic addr_t tap_offset(addr_t a);
    addr_t off;
    off = a - TAP_BASE;
    return off >> 2;
  endfunction

  function automatic logic is_tap(addr_t a);
    return (a >= TAP_BASE) && (a < TAP_BASE + TAP_WINDOW) && (tap_offset(a) < TAP_MAX);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  assign wr_pend = awvalid && wvalid;
  assign wr_en   = awready && wr_pend;
  assign rd_en   = arready && arvalid;
  assign busy    = (ap_state == AP_BUSY);

  // a pending write blocks the read address channel
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      awready  <= 1'b0;
      wready   <= 1'b0;
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      rd_tap_q <= 1'b0;
    end else begin
      awready  <= wr_pend && !awready;
      wready   <= wr_pend && !awready;
      arready  <= arvalid && !arready && !rvalid && !wr_pend;
      rd_tap_q <= rd_en && is_tap(araddr) && !busy;
      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ap_word               = '0;
    ap_word[AP_DONE_BIT]  = (ap_state == AP_DONE);
    ap_word[AP_IDLE_BIT]  = (ap_state != AP_BUSY);
  end

  // coefficient data comes from the RAM a cycle later
  always_comb begin
    if (araddr == REG_AP_CTRL) begin
      rd_sel = ap_word;
    end else if (araddr == REG_DATA_LEN) begin
      rd_sel = data_len_q;
    end else if (araddr == REG_TAP_NUM) begin
      rd_sel = tap_num_q;
    end else begin
      rd_sel = RD_INVALID;
    end
  end

  // hold RAM data once captured, writes may reuse the port
  always_ff @(posedge axis_clk) begin
    if (rd_en) begin
      rd_word_q <= rd_sel;
    end else if (rd_tap_q) begin
      rd_word_q <= tap_rw.rdata;
    end
  end

  assign rdata = rd_tap_q ? tap_rw.rdata : rd_word_q;

  // tap RAM port, no coefficient access during a run
  always_comb begin
    tap_rw.en    = 1'b0;
    tap_rw.we    = 1'b0;
    tap_rw.addr  = tap_idx_t'(tap_offset(araddr));
    tap_rw.wdata = wdata;
    if (wr_en && is_tap(awaddr) && !busy) begin
      tap_rw.en   = 1'b1;
      tap_rw.we   = 1'b1;
      tap_rw.addr = tap_idx_t'(tap_offset(awaddr));
    end else if (rd_en && is_tap(araddr) && !busy) begin
      tap_rw.en = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // config registers and ap control
  //////////////////////////////////////////////////////////////////////

  // index of the last tap, tap_num clamped to 1..TAP_MAX
  always_comb begin
    if (tap_num_q == '0) begin
      last_tap = '0;
    end else if (tap_num_q >= TAP_MAX) begin
      last_tap = tap_idx_t'(TAP_MAX - 1);
    end else begin
      last_tap = tap_idx_t'(tap_num_q - 1'b1);
    end
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      ap_state   <= AP_IDLE;
      start      <= 1'b0;
      tap_count  <= '0;
      data_len_q <= '0;
      tap_num_q  <= '0;
    end else begin
      start <= 1'b0;
      if (wr_en && awaddr == REG_DATA_LEN) begin
        data_len_q <= wdata;
      end
      if (wr_en && awaddr == REG_TAP_NUM) begin
        tap_num_q <= wdata;
      end
      case (ap_state)
        AP_IDLE: begin
          if (wr_en && awaddr == REG_AP_CTRL && wdata[AP_START_BIT]) begin
            ap_state  <= AP_BUSY;
            start     <= 1'b1;
            tap_count <= last_tap;
          end
        end
        AP_BUSY: begin
          if (run_done) begin
            ap_state <= AP_DONE;
          end
        end
        AP_DONE: begin
          // done clears on read
          if (rd_en && araddr == REG_AP_CTRL) begin
            ap_state <= AP_IDLE;
          end
        end
        default: begin
          ap_state <= AP_IDLE;
        end
      endcase
    end
  end

  // read data phase always follows its own address phase
  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    $rose(rvalid) |-> $past(arready) && !arready);

  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    start |-> ap_state == AP_BUSY && $past(ap_state) == AP_IDLE);

endmodule

`default_nettype wire

// File: source/fir_accel.sv
`timescale 1ns/1ps
`default_nettype none

module fir_accel
  import fir_bus_pkg::*;
  import fir_dsp_pkg::*;
#(
  parameter int TAP_MAX = TAP_MAX_DEF
) (
  input  wire logic    axis_clk,
  input  wire logic    axis_rst_n,
  input  wire logic    awvalid,
  input  wire addr_t   awaddr,
  output logic         awready,
  input  wire logic    wvalid,
  input  wire word_t   wdata,
  output logic         wready,
  input  wire logic    arvalid,
  input  wire addr_t   araddr,
  output logic         arready,
  output logic         rvalid,
  output word_t        rdata,
  input  wire logic    rready,
  input  wire logic    ss_tvalid,
  input  wire sample_t ss_tdata,
  input  wire logic    ss_tlast,
  output logic         ss_tready,
  output logic         sm_tvalid,
  output sample_t      sm_tdata,
  output logic         sm_tlast,
  input  wire logic    sm_tready
);

  logic     start;
  logic     run_done;
  tap_idx_t tap_count;
  logic     tap_rd_en;
  tap_idx_t tap_rd_addr;
  coef_t    tap_rd_data;

  sram_rw_if #(.AW($bits(tap_idx_t)), .DW(DATA_W)) tap_rw ();
  sram_rw_if #(.AW($bits(tap_idx_t)), .DW(DATA_W)) smp_rw ();

  axil_cfg #(.TAP_MAX(TAP_MAX)) u_axil_cfg (
    .axis_clk  (axis_clk),
    .axis_rst_n(axis_rst_n),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awready   (awready),
    .wvalid    (wvalid),
    .wdata     (wdata),
    .wready    (wready),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .rready    (rready),
    .tap_rw    (tap_rw.host),
    .start     (start),
    .tap_count (tap_count),
    .run_done  (run_done)
  );

  fir_engine #(.TAP_MAX(TAP_MAX)) u_fir_engine (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .start      (start),
    .tap_count  (tap_count),
    .ss_tvalid  (ss_tvalid),
    .ss_tdata   (ss_tdata),
    .ss_tlast   (ss_tlast),
    .sm_tready  (sm_tready),
    .tap_rd_data(tap_rd_data),
    .run_done   (run_done),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .tap_rd_en  (tap_rd_en),
    .tap_rd_addr(tap_rd_addr),
    .smp_rw     (smp_rw.host)
  );

  // coefficients, host on the rw port and engine on the read port
  fir_sram #(.DEPTH(TAP_MAX)) u_tap_ram (
    .axis_clk(axis_clk),
    .rw      (tap_rw.mem),
    .rd_en   (tap_rd_en),
    .rd_addr (tap_rd_addr),
    .rd_data (tap_rd_data)
  );

  // sample history, engine uses the rw port only
  fir_sram #(.DEPTH(TAP_MAX)) u_smp_ram (
    .axis_clk(axis_clk),
    .rw      (smp_rw.mem),
    .rd_en   (1'b0),
    .rd_addr ('0),
    .rd_data ()
  );

endmodule

`default_nettype wire

// File: source/fir_bus_pkg.sv
`default_nettype none

package fir_bus_pkg;

  // AXI-Lite widths
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

  // register map, byte offsets
  localparam addr_t REG_AP_CTRL  = 12'h000;
  localparam addr_t REG_DATA_LEN = 12'h010;
  localparam addr_t REG_TAP_NUM  = 12'h014;
  localparam addr_t TAP_BASE     = 12'h080;
  // coefficient window in bytes, 0x80 up to 0xff
  localparam int    TAP_WINDOW   = 128;

  // ap_ctrl bits
  localparam int AP_START_BIT = 0;
  localparam int AP_DONE_BIT  = 1;
  localparam int AP_IDLE_BIT  = 2;

  localparam word_t RD_INVALID = '1;

  typedef enum logic [1:0] {
    AP_IDLE,
    AP_BUSY,
    AP_DONE
  } ap_state_e;

endpackage

`default_nettype wire

// File: source/fir_dsp_pkg.sv
`default_nettype none

package fir_dsp_pkg;

  typedef logic [31:0] sample_t;
  typedef logic [31:0] coef_t;

  // default depth of both RAMs
  localparam int TAP_MAX_DEF = 32;

  // tap and history index, wide enough for 64 taps
  typedef logic [5:0] tap_idx_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_WAIT,
    ENG_STORE,
    ENG_MAC,
    ENG_FLUSH,
    ENG_OUT
  } eng_state_e;

endpackage

`default_nettype wire

// File: source/fir_engine.sv
`timescale 1ns/1ps
`default_nettype none

module fir_engine
  import fir_dsp_pkg::*;
#(
  parameter int TAP_MAX = TAP_MAX_DEF
) (
  input  wire logic     axis_clk,
  input  wire logic     axis_rst_n,
  input  wire logic     start,
  // index of the last tap held for the run
  input  wire tap_idx_t tap_count,
  input  wire logic     ss_tvalid,
  input  wire sample_t  ss_tdata,
  input  wire logic     ss_tlast,
  input  wire logic     sm_tready,
  input  wire coef_t    tap_rd_data,
  output logic          run_done,
  output logic          ss_tready,
  output logic          sm_tvalid,
  output sample_t       sm_tdata,
  output logic          sm_tlast,
  output logic          tap_rd_en,
  output tap_idx_t      tap_rd_addr,
  sram_rw_if.host       smp_rw
);

  eng_state_e state;
  eng_state_e state_nxt;
  tap_idx_t   head_q;
  tap_idx_t   fill_q;
  tap_idx_t   idx_q;
  tap_idx_t   rd_ptr_q;
  logic       last_q;
  logic       rd_v_q;
  logic       prod_v_q;
  sample_t    smp_q;
  sample_t    prod_q;
  sample_t    acc_q;

  //////////////////////////////////////////////////////////////////////
  // engine FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ENG_IDLE: begin
        if (start) begin
          state_nxt = ENG_WAIT;
        end
      end
      ENG_WAIT: begin
        if (ss_tvalid) begin
          state_nxt = ENG_STORE;
        end
      end
      ENG_STORE: begin
        state_nxt = ENG_MAC;
      end
      ENG_MAC: begin
        // fill_q is the oldest valid history index
        if (idx_q == fill_q) begin
          state_nxt = ENG_FLUSH;
        end
      end
      ENG_FLUSH: begin
        // last product lands in the accumulator on this edge
        if (!rd_v_q) begin
          state_nxt = ENG_OUT;
        end
      end
      ENG_OUT: begin
        if (sm_tready) begin
          state_nxt = last_q ? ENG_IDLE : ENG_WAIT;
        end
      end
      default: begin
        state_nxt = ENG_IDLE;
      end
    endcase
  end

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state    <= ENG_IDLE;
      head_q   <= '0;
      fill_q   <= '0;
      idx_q    <= '0;
      rd_ptr_q <= '0;
      last_q   <= 1'b0;
      rd_v_q   <= 1'b0;
      prod_v_q <= 1'b0;
    end else begin
      state    <= state_nxt;
      rd_v_q   <= (state == ENG_MAC);
      prod_v_q <= rd_v_q;
      // fresh history for every run
      if (start) begin
        head_q <= '0;
        fill_q <= '0;
      end
      case (state)
        ENG_WAIT: begin
          if (ss_tvalid) begin
            last_q <= ss_tlast;
          end
        end
        ENG_STORE: begin
          idx_q    <= '0;
          rd_ptr_q <= head_q;
        end
        ENG_MAC: begin
          idx_q    <= idx_q + 1'b1;
          rd_ptr_q <= (rd_ptr_q == '0) ? tap_count : rd_ptr_q - 1'b1;
        end
        ENG_OUT: begin
          if (sm_tready) begin
            head_q <= (head_q == tap_count) ? '0 : head_q + 1'b1;
            if (fill_q != tap_count) begin
              fill_q <= fill_q + 1'b1;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // multiply-accumulate
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge axis_clk) begin
    if (ss_tready) begin
      smp_q <= ss_tdata;
    end
    if (rd_v_q) begin
      prod_q <= smp_rw.rdata * tap_rd_data;
    end
    if (state == ENG_STORE) begin
      acc_q <= '0;
    end else if (prod_v_q) begin
      acc_q <= acc_q + prod_q;
    end
  end

  // sample write at head then reads walking back from head
  assign smp_rw.en    = (state == ENG_STORE) || (state == ENG_MAC);
  assign smp_rw.we    = (state == ENG_STORE);
  assign smp_rw.addr  = (state == ENG_STORE) ? head_q : rd_ptr_q;
  assign smp_rw.wdata = smp_q;

  assign tap_rd_en   = (state == ENG_MAC);
  assign tap_rd_addr = idx_q;

  assign ss_tready = (state == ENG_WAIT) && ss_tvalid;
  assign sm_tvalid = (state == ENG_OUT);
  assign sm_tdata  = acc_q;
  assign sm_tlast  = sm_tvalid && last_q;
  assign run_done  = sm_tvalid && sm_tready && last_q;

  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast));

  // no new sample until the previous result has left
  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    ss_tready |-> !sm_tvalid);

  assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    start |-> tap_count < TAP_MAX);

endmodule

`default_nettype wire

// File: source/fir_sram.sv
`timescale 1ns/1ps
`default_nettype none

module fir_sram
  import fir_bus_pkg::*;
  import fir_dsp_pkg::*;
#(
  parameter int DEPTH = TAP_MAX_DEF
) (
  input  wire logic     axis_clk,
  sram_rw_if.mem        rw,
  input  wire logic     rd_en,
  input  wire tap_idx_t rd_addr,
  output word_t         rd_data
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  word_t mem [DEPTH];

  // read/write port, write-first
  always_ff @(posedge axis_clk) begin
    if (rw.en) begin
      if (rw.we) begin
        mem[rw.addr[IDX_W-1:0]] <= rw.wdata;
        rw.rdata <= rw.wdata;
      end else begin
        rw.rdata <= mem[rw.addr[IDX_W-1:0]];
      end
    end
  end

  // read-only port
  always_ff @(posedge axis_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr[IDX_W-1:0]];
    end
  end

endmodule

`default_nettype wire

// File: source/sram_rw_if.sv
`timescale 1ns/1ps
`default_nettype none

// one read/write port of a synchronous RAM
interface sram_rw_if #(
  parameter int AW = 6,
  parameter int DW = 32
) ();

  logic          en;
  logic          we;
  logic [AW-1:0] addr;
  logic [DW-1:0] wdata;
  // valid one cycle after en
  logic [DW-1:0] rdata;

  modport host (output en, output we, output addr, output wdata, input rdata);
  modport mem  (input en, input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

// File: tb/fir_accel_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fir_accel_checker
  import fir_bus_pkg::*;
  import fir_dsp_pkg::*;
#(
  parameter int TAP_MAX = TAP_MAX_DEF
) (
  input  wire logic    axis_clk,
  input  wire logic    axis_rst_n,
  input  wire logic    awvalid,
  input  wire addr_t   awaddr,
  input  wire logic    awready,
  input  wire logic    wvalid,
  input  wire word_t   wdata,
  input  wire logic    wready,
  input  wire logic    arvalid,
  input  wire addr_t   araddr,
  input  wire logic    arready,
  input  wire logic    rvalid,
  input  wire word_t   rdata,
  input  wire logic    rready,
  input  wire logic    ss_tvalid,
  input  wire sample_t ss_tdata,
  input  wire logic    ss_tlast,
  input  wire logic    ss_tready,
  input  wire logic    sm_tvalid,
  input  wire sample_t sm_tdata,
  input  wire logic    sm_tlast,
  input  wire logic    sm_tready,
  output int           errors,
  output int           checks
);

  // mirror of the register map and the ap state
  word_t   coefs [TAP_MAX];
  word_t   data_len_m;
  word_t   tap_num_m;
  logic    busy_m;
  logic    done_m;
  int      ntaps;
  word_t   exp_rd;
  sample_t hist [$];
  sample_t exp_data [$];
  logic    exp_last [$];

  function automatic logic in_window(addr_t a);
    int idx;
    idx = (int'(a) - int'(TAP_BASE)) / 4;
    return (a >= TAP_BASE) && (a < TAP_BASE + TAP_WINDOW) && (idx < TAP_MAX);
  endfunction

  function automatic word_t expect_read(addr_t a);
    word_t w;
    w = RD_INVALID;
    if (a == REG_AP_CTRL) begin
      w = '0;
      w[AP_IDLE_BIT] = !busy_m;
      w[AP_DONE_BIT] = done_m;
    end else if (a == REG_DATA_LEN) begin
      w = data_len_m;
    end else if (a == REG_TAP_NUM) begin
      w = tap_num_m;
    end else if (in_window(a) && !busy_m) begin
      w = coefs[(int'(a) - int'(TAP_BASE)) / 4];
    end
    return w;
  endfunction

  // y[n] is the sum of h[i] * x[n-i] with samples before the run as zero
  function automatic sample_t fir_ref();
    sample_t acc;
    int      n;
    int      i;
    acc = '0;
    n = hist.size() - 1;
    for (i = 0; i < ntaps; i++) begin
      if (n - i >= 0) begin
        acc = acc + coefs[i] * hist[n - i];
      end
    end
    return acc;
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic note_write(input addr_t a, input word_t d);
    if (a == REG_DATA_LEN) begin
      data_len_m = d;
    end else if (a == REG_TAP_NUM) begin
      tap_num_m = d;
    end else if (a == REG_AP_CTRL) begin
      // start only counts from idle
      if (d[AP_START_BIT] && !busy_m && !done_m) begin
        busy_m = 1'b1;
        if (tap_num_m == '0) begin
          ntaps = 1;
        end else if (tap_num_m > TAP_MAX) begin
          ntaps = TAP_MAX;
        end else begin
          ntaps = int'(tap_num_m);
        end
        if (exp_data.size() != 0) begin
          errors++;
          $display("new run started at t=%0t with %0d results of the last run missing",
                   $time, exp_data.size());
        end
        hist.delete();
        exp_data.delete();
        exp_last.delete();
      end
    end else if (in_window(a) && !busy_m) begin
      coefs[(int'(a) - int'(TAP_BASE)) / 4] = d;
    end
  endtask

  task automatic check_output();
    sample_t e_data;
    logic    e_last;
    if (exp_data.size() == 0) begin
      errors++;
      $display("stream output at t=%0t with no sample waiting for a result", $time);
    end else begin
      e_data = exp_data.pop_front();
      e_last = exp_last.pop_front();
      compare_word("sm_tdata", e_data, sm_tdata);
      compare_word("sm_tlast", word_t'(e_last), word_t'(sm_tlast));
      if (e_last) begin
        busy_m = 1'b0;
        done_m = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // handshake monitor
  //////////////////////////////////////////////////////////////////////

  // read expectation is taken before this edge's model updates
  always @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      busy_m     = 1'b0;
      done_m     = 1'b0;
      data_len_m = '0;
      tap_num_m  = '0;
      ntaps      = 1;
      exp_rd     = RD_INVALID;
      errors     = 0;
      checks     = 0;
      hist.delete();
      exp_data.delete();
      exp_last.delete();
    end else begin
      if (rvalid && rready) begin
        compare_word("rdata", exp_rd, rdata);
      end
      if (arvalid && arready) begin
        exp_rd = expect_read(araddr);
        if (araddr == REG_AP_CTRL) begin
          done_m = 1'b0;
        end
      end
      // both write channels are accepted together
      if (awready !== wready) begin
        errors++;
        $display("awready and wready were not raised together at t=%0t", $time);
      end
      if (awvalid && wvalid && awready && wready) begin
        note_write(awaddr, wdata);
      end
      if (sm_tvalid && sm_tready) begin
        check_output();
      end
      if (ss_tvalid && ss_tready) begin
        hist.push_back(ss_tdata);
        exp_data.push_back(fir_ref());
        exp_last.push_back(ss_tlast);
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/fir_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fir_accel_tb
  import fir_bus_pkg::*;
  import fir_dsp_pkg::*;
();

  localparam int TAP_MAX = TAP_MAX_DEF;
  localparam int N_SMP   = 20;
  localparam int N_RUNS  = 4;
  localparam int LIMIT   = 2000 + N_SMP * N_RUNS * (TAP_MAX + 12) * 4;

  logic    axis_clk = 1'b0;
  logic    axis_rst_n;
  logic    awvalid;
  addr_t   awaddr;
  logic    awready;
  logic    wvalid;
  word_t   wdata;
  logic    wready;
  logic    arvalid;
  addr_t   araddr;
  logic    arready;
  logic    rvalid;
  word_t   rdata;
  logic    rready;
  logic    ss_tvalid;
  sample_t ss_tdata;
  logic    ss_tlast;
  logic    ss_tready;
  logic    sm_tvalid;
  sample_t sm_tdata;
  logic    sm_tlast;
  logic    sm_tready;
  int      errors;
  int      checks;

  integer  seed;
  int      cycles = 0;
  int      err_mark;
  int      tests_pass;
  int      tests_fail;
  int      i;
  sample_t smp [N_SMP];

  fir_accel #(.TAP_MAX(TAP_MAX)) fir_accel_inst (.*);

  fir_accel_checker #(.TAP_MAX(TAP_MAX)) u_checker (.*);

  always #4 axis_clk = ~axis_clk;

  always @(posedge axis_clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus and stream drivers
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input addr_t addr, input word_t data);
    @(posedge axis_clk);
    #1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    @(negedge axis_clk);
    while (!(awready && wready)) @(negedge axis_clk);
    @(posedge axis_clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  // address phase then a single data beat with rready held high
  task automatic read_reg(input addr_t addr);
    @(posedge axis_clk);
    #1;
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge axis_clk);
    while (!arready) @(negedge axis_clk);
    @(posedge axis_clk);
    #1;
    arvalid = 1'b0;
    @(negedge axis_clk);
    while (!rvalid) @(negedge axis_clk);
    @(posedge axis_clk);
  endtask

  task automatic load_taps(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      write_reg(TAP_BASE + addr_t'(4 * k), $random(seed));
    end
  endtask

  task automatic send_samples();
    int k;
    for (k = 0; k < N_SMP; k++) begin
      @(posedge axis_clk);
      #1;
      ss_tvalid = 1'b1;
      ss_tdata  = smp[k];
      ss_tlast  = (k == N_SMP - 1);
      @(negedge axis_clk);
      while (!ss_tready) @(negedge axis_clk);
    end
    @(posedge axis_clk);
    #1;
    ss_tvalid = 1'b0;
    ss_tlast  = 1'b0;
  endtask

  task automatic take_results(input bit stalls);
    int got;
    got = 0;
    while (got < N_SMP) begin
      @(posedge axis_clk);
      #1;
      sm_tready = stalls ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge axis_clk);
      if (sm_tvalid && sm_tready) begin
        got++;
      end
    end
    @(posedge axis_clk);
    #1;
    sm_tready = 1'b0;
  endtask

  task automatic run_filter(input bit stalls, input bit probe);
    write_reg(REG_AP_CTRL, 32'h1);
    if (probe) begin
      read_reg(REG_AP_CTRL);
      read_reg(TAP_BASE);
    end
    fork
      send_samples();
      take_results(stalls);
    join
    // first read sees done and clears it
    read_reg(REG_AP_CTRL);
    read_reg(REG_AP_CTRL);
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: %0d mismatches", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'h5b42;
    axis_rst_n = 1'b0;
    awvalid    = 1'b0;
    awaddr     = '0;
    wvalid     = 1'b0;
    wdata      = '0;
    arvalid    = 1'b0;
    araddr     = '0;
    rready     = 1'b1;
    ss_tvalid  = 1'b0;
    ss_tdata   = '0;
    ss_tlast   = 1'b0;
    sm_tready  = 1'b0;
    err_mark   = 0;
    tests_pass = 0;
    tests_fail = 0;
    repeat (10) @(posedge axis_clk);
    #1;
    axis_rst_n = 1'b1;

    read_reg(REG_AP_CTRL);
    write_reg(REG_DATA_LEN, N_SMP);
    write_reg(REG_TAP_NUM, 11);
    load_taps(TAP_MAX);
    read_reg(REG_DATA_LEN);
    read_reg(REG_TAP_NUM);
    for (i = 0; i < TAP_MAX; i++) begin
      read_reg(TAP_BASE + addr_t'(4 * i));
    end
    // holes in the map
    read_reg(12'h020);
    read_reg(12'h100);
    end_test("1 register access");

    load_taps(11);
    for (i = 0; i < N_SMP; i++) begin
      smp[i] = $random(seed);
    end
    run_filter(1'b0, 1'b0);
    end_test("2 filter run");

    run_filter(1'b1, 1'b0);
    end_test("3 output back-pressure");

    run_filter(1'b0, 1'b1);
    end_test("4 status during run");

    write_reg(REG_TAP_NUM, TAP_MAX);
    load_taps(TAP_MAX);
    for (i = 0; i < N_SMP; i++) begin
      smp[i] = $random(seed);
    end
    run_filter(1'b1, 1'b0);
    end_test("5 full tap count");

    $display("tests passed %0d failed %0d, %0d checks", tests_pass, tests_fail, checks);
    if (tests_fail == 0 && errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
